/* src/sifhPkg.sv */
package sifhPkg;

    // timestamp split into coarse and fine bin fields
    localparam int TS_W     = 12;
    localparam int COARSE_W = 6;   // upper bits of a timestamp
    localparam int FINE_W   = 6;   // lower bits of a timestamp

    // bin counts saturate at the top of this width
    localparam int CNT_W    = 8;

    // frame sequencer phases
    typedef enum logic [1:0] {
        seqClear,   // both memories being zeroed
        seqAccum,   // credits out, samples counted
        seqScan,    // peak search in both builders
        seqReport   // combine peaks, update window
    } seqState_t;

    // histogram builder phases
    typedef enum logic [1:0] {
        hsClear,    // zero fill of the bin memory
        hsIdle,     // peak result held
        hsAccum,    // read-modify-write of samples
        hsScan      // walk all bins for the maximum
    } histState_t;

endpackage

/* src/histRam.sv */
`timescale 1ns/10ps

module histRam #(
    parameter int BIN_W = sifhPkg::COARSE_W,
    parameter int CNT_W = sifhPkg::CNT_W
) (
    input  logic             clk,
    input  logic             we,
    input  logic [BIN_W-1:0] waddr,
    input  logic [CNT_W-1:0] wdata,
    input  logic [BIN_W-1:0] raddr,
    output logic [CNT_W-1:0] rdata
);

    logic [CNT_W-1:0] mem [2**BIN_W];   // one count per bin

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* src/histBuilder.sv */
`timescale 1ns/10ps

module histBuilder #(
    parameter int BIN_W = sifhPkg::COARSE_W
) (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      clear,
    input  logic                      sampleValid,
    input  logic [BIN_W-1:0]          sampleBin,
    input  logic                      scan,
    output logic                      ready,
    output logic [BIN_W-1:0]          peakBin,
    output logic [sifhPkg::CNT_W-1:0] peakCount
);
    import sifhPkg::*;

    localparam logic [BIN_W-1:0] LAST_BIN = '1;
    localparam logic [CNT_W-1:0] CNT_MAX  = '1;

    histState_t       state;
    logic [BIN_W-1:0] addr;         // clear and scan address walker
    logic             scanIssued;   // every bin has been read
    logic             rdPend;       // read data arrives this cycle
    logic [BIN_W-1:0] rdBin;        // bin belonging to the read data

    // read stage
    logic             s1Valid;
    logic [BIN_W-1:0] s1Bin;
    // write stage
    logic             wValid;
    logic [BIN_W-1:0] wBin;
    logic [CNT_W-1:0] wCount;
    // write committed at the last edge that a read-first read missed
    logic             pValid;
    logic [BIN_W-1:0] pBin;
    logic [CNT_W-1:0] pCount;

    logic [CNT_W-1:0] curCount;
    logic [CNT_W-1:0] incCount;

    logic             ramWe;
    logic [BIN_W-1:0] ramWaddr;
    logic [CNT_W-1:0] ramWdata;
    logic [BIN_W-1:0] ramRaddr;
    logic [CNT_W-1:0] ramRdata;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= hsIdle;
            addr       <= '0;
            scanIssued <= 1'b0;
            rdPend     <= 1'b0;
        end else begin
            rdPend <= 1'b0;
            case (state)
                hsClear: begin
                    addr <= addr + 1'b1;
                    if (addr == LAST_BIN) begin
                        state <= hsAccum;   // memory zeroed so samples may follow
                    end
                end
                hsScan: begin
                    if (!scanIssued) begin
                        rdPend <= 1'b1;
                        addr   <= addr + 1'b1;
                        if (addr == LAST_BIN) begin
                            scanIssued <= 1'b1;
                        end
                    end else if (rdPend) begin
                        state <= hsIdle;   // last bin compared
                    end
                end
                default: begin
                end
            endcase
            if (clear) begin
                state <= hsClear;
                addr  <= '0;
            end else if (scan) begin
                state      <= hsScan;
                addr       <= '0;
                scanIssued <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdBin <= addr;
    end

    // strictly greater keeps the lowest bin on a tie
    always_ff @(posedge clk) begin
        if (scan) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (rdPend && (ramRdata > peakCount)) begin
            peakBin   <= rdBin;
            peakCount <= ramRdata;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            wValid  <= 1'b0;
            pValid  <= 1'b0;
        end else begin
            s1Valid <= sampleValid && (state == hsAccum);
            wValid  <= s1Valid;
            pValid  <= wValid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin  <= sampleBin;
        wBin   <= s1Bin;
        wCount <= incCount;
        pBin   <= wBin;
        pCount <= wCount;
    end

    // newest in-flight count of the same bin wins over memory data
    always_comb begin
        if (wValid && (wBin == s1Bin)) begin
            curCount = wCount;
        end else if (pValid && (pBin == s1Bin)) begin
            curCount = pCount;
        end else begin
            curCount = ramRdata;
        end
    end

    assign incCount = (curCount == CNT_MAX) ? curCount : curCount + 1'b1;   // saturate

    assign ramWe    = (state == hsClear) || wValid;
    assign ramWaddr = (state == hsClear) ? addr : wBin;
    assign ramWdata = (state == hsClear) ? '0 : wCount;
    assign ramRaddr = (state == hsScan) ? addr : sampleBin;

    assign ready = (state == hsIdle) || (state == hsAccum);

    histRam #(
        .BIN_W(BIN_W),
        .CNT_W(CNT_W)
    ) ram0 (
        .clk  (clk),
        .we   (ramWe),
        .waddr(ramWaddr),
        .wdata(ramWdata),
        .raddr(ramRaddr),
        .rdata(ramRdata)
    );

endmodule

/* src/frameSequencer.sv */
`timescale 1ns/10ps

module frameSequencer #(
    parameter int FRAME_LEN  = 200,
    parameter int CREDIT_MAX = 4
) (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         tsValid,
    input  logic [sifhPkg::TS_W-1:0]     ts,
    input  logic                         coarseReady,
    input  logic [sifhPkg::COARSE_W-1:0] coarsePeakBin,
    input  logic [sifhPkg::CNT_W-1:0]    coarsePeakCount,
    input  logic                         fineReady,
    input  logic [sifhPkg::FINE_W-1:0]   finePeakBin,
    input  logic [sifhPkg::CNT_W-1:0]    finePeakCount,
    output logic                         credit,
    output logic                         histClear,
    output logic                         histScan,
    output logic                         coarseValid,
    output logic                         fineValid,
    output logic [sifhPkg::COARSE_W-1:0] sampleCoarse,
    output logic [sifhPkg::FINE_W-1:0]   sampleFine,
    output logic                         peakValid,
    output logic [sifhPkg::TS_W-1:0]     peakTime,
    output logic [sifhPkg::CNT_W-1:0]    peakCount,
    output logic                         fineLock
);
    import sifhPkg::*;

    localparam int FCNT_W = $clog2(FRAME_LEN + 1);
    localparam int OCNT_W = $clog2(CREDIT_MAX + 1);

    seqState_t           state;
    logic [FCNT_W-1:0]   issued;        // credits granted this frame
    logic [FCNT_W-1:0]   received;      // timestamps taken this frame
    logic [OCNT_W-1:0]   outstanding;   // credits not yet spent
    logic [1:0]          drain;         // builder pipeline flush steps
    logic [COARSE_W-1:0] window;        // coarse bin watched by the fine builder
    logic [TS_W-1:0]     tsReg;
    logic [COARSE_W-1:0] tsCoarse;
    logic                issue;
    logic                lastTs;
    logic                lock;

    assign tsCoarse = ts[TS_W-1 -: COARSE_W];

    assign issue = (state == seqAccum)
                && (outstanding < OCNT_W'(CREDIT_MAX))
                && (issued < FCNT_W'(FRAME_LEN));

    assign lastTs = (state == seqAccum) && tsValid && (received == FCNT_W'(FRAME_LEN - 1));

    assign lock = (coarsePeakBin == window);

    assign sampleCoarse = tsReg[TS_W-1 -: COARSE_W];
    assign sampleFine   = tsReg[FINE_W-1:0];

    // credit pulse and outstanding count
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            credit      <= 1'b0;
            outstanding <= '0;
        end else begin
            credit <= issue;
            case ({issue, tsValid})
                2'b10: outstanding <= outstanding + 1'b1;
                2'b01: begin
                    if (outstanding != '0) begin
                        outstanding <= outstanding - 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tsValid) begin
            tsReg <= ts;
        end
    end

    // fine samples only from inside the window
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            coarseValid <= 1'b0;
            fineValid   <= 1'b0;
        end else begin
            coarseValid <= tsValid;
            fineValid   <= tsValid && (tsCoarse == window);
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= seqClear;
            histClear <= 1'b1;   // first cycle out of reset starts the clear
            histScan  <= 1'b0;
            peakValid <= 1'b0;
            issued    <= '0;
            received  <= '0;
            drain     <= '0;
            window    <= '0;
        end else begin
            histClear <= 1'b0;
            histScan  <= 1'b0;
            peakValid <= 1'b0;
            case (state)
                seqClear: begin
                    issued   <= '0;
                    received <= '0;
                    drain    <= '0;
                    if (!histClear && coarseReady && fineReady) begin
                        state <= seqAccum;
                    end
                end
                seqAccum: begin
                    if (issue) begin
                        issued <= issued + 1'b1;
                    end
                    if (tsValid) begin
                        received <= received + 1'b1;
                    end
                    if (lastTs) begin
                        drain <= 2'd1;
                    end else if (drain == 2'd1) begin
                        drain <= 2'd2;
                    end else if (drain == 2'd2) begin
                        drain    <= '0;
                        histScan <= 1'b1;   // last write is committed by now
                        state    <= seqScan;
                    end
                end
                seqScan: begin
                    if (!histScan && coarseReady && fineReady) begin
                        state <= seqReport;
                    end
                end
                seqReport: begin
                    peakValid <= 1'b1;
                    window    <= coarsePeakBin;   // next frame looks here
                    histClear <= 1'b1;
                    state     <= seqClear;
                end
                default: state <= seqClear;
            endcase
        end
    end

    // result holds until the next report
    always_ff @(posedge clk) begin
        if (state == seqReport) begin
            fineLock <= lock;
            if (lock) begin
                peakTime  <= {window, finePeakBin};
                peakCount <= finePeakCount;
            end else begin
                peakTime  <= {coarsePeakBin, {FINE_W{1'b0}}};
                peakCount <= coarsePeakCount;
            end
        end
    end

endmodule

/* src/sifhTop.sv */
`timescale 1ns/10ps

module sifhTop #(
    parameter int FRAME_LEN  = 200,
    parameter int CREDIT_MAX = 4
) (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      tsValid,
    input  logic [sifhPkg::TS_W-1:0]  ts,
    output logic                      credit,
    output logic                      peakValid,
    output logic [sifhPkg::TS_W-1:0]  peakTime,
    output logic [sifhPkg::CNT_W-1:0] peakCount,
    output logic                      fineLock
);
    import sifhPkg::*;

    logic                histClear;
    logic                histScan;
    logic                coarseValid;
    logic                fineValid;
    logic [COARSE_W-1:0] sampleCoarse;
    logic [FINE_W-1:0]   sampleFine;
    logic                coarseReady;
    logic [COARSE_W-1:0] coarsePeakBin;
    logic [CNT_W-1:0]    coarsePeakCount;
    logic                fineReady;
    logic [FINE_W-1:0]   finePeakBin;
    logic [CNT_W-1:0]    finePeakCount;

    frameSequencer #(
        .FRAME_LEN (FRAME_LEN),
        .CREDIT_MAX(CREDIT_MAX)
    ) seq0 (
        .clk            (clk),
        .res            (res),
        .tsValid        (tsValid),
        .ts             (ts),
        .coarseReady    (coarseReady),
        .coarsePeakBin  (coarsePeakBin),
        .coarsePeakCount(coarsePeakCount),
        .fineReady      (fineReady),
        .finePeakBin    (finePeakBin),
        .finePeakCount  (finePeakCount),
        .credit         (credit),
        .histClear      (histClear),
        .histScan       (histScan),
        .coarseValid    (coarseValid),
        .fineValid      (fineValid),
        .sampleCoarse   (sampleCoarse),
        .sampleFine     (sampleFine),
        .peakValid      (peakValid),
        .peakTime       (peakTime),
        .peakCount      (peakCount),
        .fineLock       (fineLock)
    );

    // whole range binned by the upper bits
    histBuilder #(
        .BIN_W(COARSE_W)
    ) coarse0 (
        .clk        (clk),
        .res        (res),
        .clear      (histClear),
        .sampleValid(coarseValid),
        .sampleBin  (sampleCoarse),
        .scan       (histScan),
        .ready      (coarseReady),
        .peakBin    (coarsePeakBin),
        .peakCount  (coarsePeakCount)
    );

    // window samples binned by the lower bits
    histBuilder #(
        .BIN_W(FINE_W)
    ) fine0 (
        .clk        (clk),
        .res        (res),
        .clear      (histClear),
        .sampleValid(fineValid),
        .sampleBin  (sampleFine),
        .scan       (histScan),
        .ready      (fineReady),
        .peakBin    (finePeakBin),
        .peakCount  (finePeakCount)
    );

endmodule

/* bench/sifhResult_chk.sv */
`timescale 1ns/10ps

module sifhResultChk #(
    parameter int CREDIT_MAX = 4
) (
    input logic                clk,
    input logic                res,
    input logic                credit,
    input logic                tsValid,
    input logic                peakValid,
    input sifhPkg::histState_t coarseState,
    input sifhPkg::histState_t fineState
);
    import sifhPkg::*;

    int outCnt;          // credit pulses not yet answered by a timestamp
    int failCount = 0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            outCnt <= 0;
        end else begin
            outCnt <= outCnt + int'(credit) - int'(tsValid);
        end
    end

    quietInReset: assert property (@(posedge clk) !res ##1 !res
            |-> !credit && !peakValid && (coarseState == hsIdle) && (fineState == hsIdle))
        else begin
            failCount++;
            $error("credit, peakValid or a builder state is active during reset");
        end

    // sequencer pulses clear in its first cycle out of reset
    clearAfterReset: assert property (@(posedge clk) $rose(res)
            |=> (coarseState == hsClear) && (fineState == hsClear))
        else begin
            failCount++;
            $error("builders did not start clearing after reset");
        end

    creditBacked: assert property (@(posedge clk) disable iff (!res) tsValid |-> outCnt > 0)
        else begin
            failCount++;
            $error("tsValid arrived with no credit outstanding");
        end

    creditLimit: assert property (@(posedge clk) disable iff (!res) outCnt <= CREDIT_MAX)
        else begin
            failCount++;
            $error("more credits outstanding than the limit allows");
        end

endmodule

bind sifhTop sifhResultChk #(
    .CREDIT_MAX(CREDIT_MAX)
) chk0 (
    .clk        (clk),
    .res        (res),
    .credit     (credit),
    .tsValid    (tsValid),
    .peakValid  (peakValid),
    .coarseState(coarse0.state),
    .fineState  (fine0.state)
);

/* bench/sifhTb.sv */
`timescale 1ns/10ps

module sifhTb;
    import sifhPkg::*;

    localparam int FRAME_LEN    = 200;
    localparam int CREDIT_MAX   = 4;
    localparam int FRAMES       = 6;
    localparam int REPEAT_FRAME = 5;   // one timestamp repeated back to back
    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = FRAME_LEN * 5 + 2 * (2**COARSE_W) + 2;
    localparam int WATCHDOG_NS  = (FRAMES * FRAME_CYCLES + 16) * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              res;
    logic              tsValid;
    logic [TS_W-1:0]   ts;
    logic              credit;
    logic              peakValid;
    logic [TS_W-1:0]   peakTime;
    logic [CNT_W-1:0]  peakCount;
    logic              fineLock;

    logic [31:0]       lfsr = 32'hcbfa;
    logic [TS_W-1:0]   nextTs;
    int                heldCredits = 0;   // credits the TDC model may spend
    int                holdOff = 0;
    int                sentCount = 0;
    int                grantCount = 0;    // credits seen since the last result
    int                resultsSeen = 0;
    int                valueErrors = 0;
    int                protocolErrors = 0;
    int                refCoarse [2**COARSE_W] = '{default: 0};
    int                refFine [2**FINE_W] = '{default: 0};
    int                refWindow = 0;
    logic [TS_W+CNT_W:0] expQ [$];        // {lock, count, time} per frame
    logic              expAvail = 1'b0;
    logic              expLock;
    logic [CNT_W-1:0]  expCount;
    logic [TS_W-1:0]   expTime;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sifhTop #(
        .FRAME_LEN (FRAME_LEN),
        .CREDIT_MAX(CREDIT_MAX)
    ) dut0 (
        .clk      (clk),
        .res      (res),
        .tsValid  (tsValid),
        .ts       (ts),
        .credit   (credit),
        .peakValid(peakValid),
        .peakTime (peakTime),
        .peakCount(peakCount),
        .fineLock (fineLock)
    );

    // fibonacci LFSR with taps 32 22 2 1
    function automatic int unsigned takeBits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // 3 of 4 in a 16 wide band around a target that jumps at frame 3
    function automatic logic [TS_W-1:0] makeTimestamp(input int frame);
        logic [TS_W-1:0] target;
        target = (frame < 3) ? 12'h5a3 : 12'hc67;
        if (frame == REPEAT_FRAME) begin
            return 12'hc6a;
        end
        if (takeBits(2) != 0) begin
            return target - 12'd8 + TS_W'(takeBits(4));
        end
        return TS_W'(takeBits(TS_W));
    endfunction

    task automatic showFront();
        expAvail = (expQ.size() != 0);
        if (expAvail) begin
            {expLock, expCount, expTime} = expQ[0];
        end
    endtask

    // peaks of the finished frame with ties going to the lowest bin
    task automatic closeFrame();
        int cPeak;
        int fPeak;
        logic lock;
        cPeak = 0;
        fPeak = 0;
        for (int b = 1; b < 2**COARSE_W; b++) begin
            if (refCoarse[b] > refCoarse[cPeak]) cPeak = b;
        end
        for (int b = 1; b < 2**FINE_W; b++) begin
            if (refFine[b] > refFine[fPeak]) fPeak = b;
        end
        lock = (cPeak == refWindow);
        if (lock) begin
            expQ.push_back({1'b1, CNT_W'(refFine[fPeak]), COARSE_W'(refWindow), FINE_W'(fPeak)});
        end else begin
            expQ.push_back({1'b0, CNT_W'(refCoarse[cPeak]), COARSE_W'(cPeak), FINE_W'(0)});
        end
        refWindow = cPeak;   // next frame watches this coarse bin
        refCoarse = '{default: 0};
        refFine   = '{default: 0};
        showFront();
    endtask

    task automatic recordSample(input logic [TS_W-1:0] t);
        int c;
        int f;
        c = t[TS_W-1 -: COARSE_W];
        f = t[FINE_W-1:0];
        if (refCoarse[c] < 255) refCoarse[c]++;
        if ((c == refWindow) && (refFine[f] < 255)) refFine[f]++;
        sentCount++;
        if (sentCount % FRAME_LEN == 0) closeFrame();
    endtask

    // TDC model spending each credit after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (res) begin
            if (credit) heldCredits++;
            if ((heldCredits > 0) && (holdOff == 0)) begin
                nextTs = makeTimestamp(sentCount / FRAME_LEN);
                tsValid <= 1'b1;
                ts      <= nextTs;
                heldCredits--;
                recordSample(nextTs);
                holdOff = (sentCount / FRAME_LEN == REPEAT_FRAME) ? 0 : takeBits(2);
            end else begin
                tsValid <= 1'b0;
                if (holdOff > 0) holdOff--;
            end
        end
    end

    always @(posedge clk) begin
        if (res) begin
            if (credit) grantCount++;
            if (peakValid) begin
                grantCount = 0;
                resultsSeen++;
                if (expAvail) void'(expQ.pop_front());
                showFront();
            end
        end
    end

    resultExpected: assert property (@(posedge clk) disable iff (!res) peakValid |-> expAvail)
        else begin
            protocolErrors++;
            $display("peakValid arrived before the frame's timestamps were all sent");
        end
    timeMatch: assert property (@(posedge clk) disable iff (!res)
            peakValid |-> peakTime == expTime)
        else begin
            valueErrors++;
            $display("error peakTime: got %h, expected %h", $sampled(peakTime), $sampled(expTime));
        end
    countMatch: assert property (@(posedge clk) disable iff (!res)
            peakValid |-> peakCount == expCount)
        else begin
            valueErrors++;
            $display("error peakCount: got %h, expected %h", $sampled(peakCount),
                $sampled(expCount));
        end
    lockMatch: assert property (@(posedge clk) disable iff (!res)
            peakValid |-> fineLock == expLock)
        else begin
            valueErrors++;
            $display("error fineLock: got %h, expected %h", $sampled(fineLock), $sampled(expLock));
        end
    creditsPerFrame: assert property (@(posedge clk) disable iff (!res)
            peakValid |-> grantCount == FRAME_LEN)
        else begin
            protocolErrors++;
            $display("frame ended after %0d credits instead of %0d", $sampled(grantCount),
                FRAME_LEN);
        end
    singlePulse: assert property (@(posedge clk) disable iff (!res) peakValid |=> !peakValid)
        else begin
            protocolErrors++;
            $display("peakValid stayed high for more than one cycle");
        end

    task automatic printCounts();
        $display("errors: %0d value, %0d protocol, %0d checker", valueErrors, protocolErrors,
            dut0.chk0.failCount);
    endtask

    initial begin
        res     = 1'b0;
        tsValid = 1'b0;
        ts      = '0;
        repeat (4) @(posedge clk);
        res <= 1'b1;
        while (resultsSeen < FRAMES) @(posedge clk);
        repeat (4) @(posedge clk);
        printCounts();
        if (valueErrors + protocolErrors + dut0.chk0.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized for all frames at the slowest TDC pace
    initial begin
        #(WATCHDOG_NS);
        $display("timeout with %0d of %0d frame results received", resultsSeen, FRAMES);
        printCounts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
src/sifhPkg.sv
src/histRam.sv
src/histBuilder.sv
src/frameSequencer.sv
src/sifhTop.sv
bench/sifhResult_chk.sv
bench/sifhTb.sv

/* Bender.yml */
package:
  name: sifh

sources:
  - src/sifhPkg.sv
  - src/histRam.sv
  - src/histBuilder.sv
  - src/frameSequencer.sv
  - src/sifhTop.sv
  - target: test
    files:
      - bench/sifhResult_chk.sv
      - bench/sifhTb.sv
